/* isa_pkg.sv */
package isa_pkg;

    // ****************************************
    // Data path widths
    // ****************************************
    localparam int XLEN        = 32;
    localparam int XLEN_BYTES  = XLEN / 8;   // Byte lanes per word
    localparam int XLEN_HALVES = XLEN / 16;  // Halfword lanes per word

    // ****************************************
    // RV32I opcodes
    // ****************************************
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // ****************************************
    // funct3 codes for loads and stores
    // ****************************************
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // One memory word, seen as byte lanes or halfword lanes
    typedef union packed {
        logic [XLEN_BYTES-1:0][7:0]   b;
        logic [XLEN_HALVES-1:0][15:0] h;
    } mem_word_u;

endpackage

/* mem_map_pkg.sv */
package mem_map_pkg;

    // ****************************************
    // Data memory geometry
    // ****************************************
    localparam int MEM_WORDS = 256;            // Word entries in the array
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);  // Word index bits

    // ****************************************
    // Fault status
    // ****************************************
    // Counter stops at all ones
    localparam int FAULT_CNT_W = 8;

endpackage

/* mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;
    import isa_pkg::*;
    import mem_map_pkg::*;

    logic [MEM_IDX_W-1:0]  addr_idx;  // Word index
    logic [XLEN-1:0]       wdata;     // Lane aligned store word
    logic [XLEN_BYTES-1:0] wstrb;     // Byte enables
    logic                  we;
    logic [XLEN-1:0]       rdata;     // Combinational read word

    modport master (
        output addr_idx,
        output wdata,
        output wstrb,
        output we,
        input  rdata
    );

    modport slave (
        input  addr_idx,
        input  wdata,
        input  wstrb,
        input  we,
        output rdata
    );

endinterface

/* mem_access_stage.sv */
`timescale 1ns/1ps

module mem_access_stage (
    input  logic [isa_pkg::XLEN-1:0] i_rs_2,
    input  logic [isa_pkg::XLEN-1:0] i_alu_out,
    input  logic [6:0]               i_opcode,
    input  logic [2:0]               i_func_3,
    input  logic                     i_valid,
    mem_bus_if.master                bus,
    output logic [isa_pkg::XLEN-1:0] o_mem_out,
    output logic                     o_is_load,
    output logic                     o_misaligned,
    output logic                     o_fault,
    output logic [isa_pkg::XLEN-1:0] o_fault_addr
);
    import isa_pkg::*;
    import mem_map_pkg::*;

    logic [1:0]            byte_off;
    logic                  ld_acc;
    logic                  st_acc;
    logic                  sz_byte;
    logic                  sz_half;
    logic                  sz_word;
    logic                  ld_unsigned;
    logic                  misaligned;
    mem_word_u             st_word;
    logic [XLEN_BYTES-1:0] st_strb;
    mem_word_u             ld_word;
    logic [7:0]            ld_byte;
    logic [15:0]           ld_half;

    assign byte_off = i_alu_out[1:0];

    // ****************************************
    // Decode
    // ****************************************
    always_comb begin
        ld_acc      = 1'b0;
        st_acc      = 1'b0;
        sz_byte     = 1'b0;
        sz_half     = 1'b0;
        sz_word     = 1'b0;
        ld_unsigned = 1'b0;
        case (i_opcode)
            OPC_LOAD: begin
                case (i_func_3)
                    F3_LB:  begin ld_acc = 1'b1; sz_byte = 1'b1; end
                    F3_LH:  begin ld_acc = 1'b1; sz_half = 1'b1; end
                    F3_LW:  begin ld_acc = 1'b1; sz_word = 1'b1; end
                    F3_LBU: begin ld_acc = 1'b1; sz_byte = 1'b1; ld_unsigned = 1'b1; end
                    F3_LHU: begin ld_acc = 1'b1; sz_half = 1'b1; ld_unsigned = 1'b1; end
                    default: ;  // Unknown width, no access
                endcase
            end
            OPC_STORE: begin
                case (i_func_3)
                    F3_SB:  begin st_acc = 1'b1; sz_byte = 1'b1; end
                    F3_SH:  begin st_acc = 1'b1; sz_half = 1'b1; end
                    F3_SW:  begin st_acc = 1'b1; sz_word = 1'b1; end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign misaligned = (sz_half & byte_off[0]) | (sz_word & (byte_off != 2'b00));

    // ****************************************
    // Store lane placement
    // ****************************************
    always_comb begin
        st_word = '0;
        st_strb = '0;
        if (st_acc) begin
            if (sz_byte) begin
                st_word.b[byte_off] = i_rs_2[7:0];
                st_strb[byte_off]   = 1'b1;
            end else if (sz_half) begin
                st_word.h[byte_off[1]]            = i_rs_2[15:0];
                st_strb[{byte_off[1], 1'b0} +: 2] = 2'b11;
            end else begin
                st_word = i_rs_2;
                st_strb = '1;
            end
        end
    end

    assign bus.addr_idx = i_alu_out[MEM_IDX_W+1:2];  // Wraps on index bits
    assign bus.wdata    = st_word;
    assign bus.wstrb    = st_strb;
    assign bus.we       = i_valid & st_acc & ~misaligned;

    // ****************************************
    // Load lane select and extension
    // ****************************************
    assign ld_word = bus.rdata;
    assign ld_byte = ld_word.b[byte_off];
    assign ld_half = ld_word.h[byte_off[1]];

    always_comb begin
        o_mem_out = '0;
        if (ld_acc) begin
            if (sz_byte) begin
                o_mem_out = {{(XLEN-8){ld_byte[7] & ~ld_unsigned}}, ld_byte};
            end else if (sz_half) begin
                o_mem_out = {{(XLEN-16){ld_half[15] & ~ld_unsigned}}, ld_half};
            end else begin
                o_mem_out = ld_word;
            end
        end
    end

    assign o_is_load    = ld_acc;
    assign o_misaligned = misaligned;
    assign o_fault      = i_valid & misaligned;  // One cycle pulse per bad access
    assign o_fault_addr = i_alu_out;

endmodule

/* data_mem_ctrl.sv */
`timescale 1ns/1ps

module data_mem_ctrl (
    input  logic     i_clk,
    input  logic     i_rst_n,
    mem_bus_if.slave bus
);
    import isa_pkg::*;
    import mem_map_pkg::*;

    logic [XLEN-1:0] mem [MEM_WORDS];

    // ****************************************
    // Byte strobed write
    // ****************************************
    always_ff @(posedge i_clk) begin
        if (bus.we && i_rst_n) begin  // No writes while held in reset
            for (int i = 0; i < XLEN_BYTES; i++) begin
                if (bus.wstrb[i]) begin
                    mem[bus.addr_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Same cycle read, sees data written at the previous edge
    assign bus.rdata = mem[bus.addr_idx];

endmodule

/* mem_fault_regs.sv */
`timescale 1ns/1ps

module mem_fault_regs (
    input  logic                               i_clk,
    input  logic                               i_rst_n,
    input  logic                               i_fault,
    input  logic [isa_pkg::XLEN-1:0]           i_fault_addr,
    input  logic                               i_fault_clr,
    output logic                               o_fault_flag,
    output logic [mem_map_pkg::FAULT_CNT_W-1:0] o_fault_count,
    output logic [isa_pkg::XLEN-1:0]           o_fault_addr
);
    import mem_map_pkg::*;

    logic cnt_full;

    assign cnt_full = (o_fault_count == {FAULT_CNT_W{1'b1}});

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_fault_flag  <= 1'b0;
            o_fault_count <= '0;
            o_fault_addr  <= '0;
        end else if (i_fault_clr) begin  // Clear wins over a new fault
            o_fault_flag  <= 1'b0;
            o_fault_count <= '0;
            o_fault_addr  <= '0;
        end else if (i_fault) begin
            o_fault_flag <= 1'b1;        // Sticky
            if (!cnt_full) begin
                o_fault_count <= o_fault_count + 1'b1;
            end
            o_fault_addr <= i_fault_addr;  // Latest fault
        end
    end

endmodule

/* mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_valid,
    input  logic [4:0]               i_rd_num,
    input  logic [isa_pkg::XLEN-1:0] i_alu_out,
    input  logic [isa_pkg::XLEN-1:0] i_mem_out,
    input  logic                     i_is_load,
    input  logic                     i_op_type,
    input  logic                     i_misaligned,
    output logic                     o_wb_valid,
    output logic                     o_wb_we,
    output logic [4:0]               o_wb_rd,
    output logic [isa_pkg::XLEN-1:0] o_wb_data
);
    import isa_pkg::*;

    logic [XLEN-1:0] wb_data_nxt;
    logic            wb_we_nxt;

    assign wb_data_nxt = i_is_load ? i_mem_out : i_alu_out;

    // x0 never written
    assign wb_we_nxt = i_valid & i_op_type & (i_rd_num != 5'd0) & ~i_misaligned;

    // ****************************************
    // Control
    // ****************************************
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
            o_wb_we    <= 1'b0;
        end else begin
            o_wb_valid <= i_valid;
            o_wb_we    <= wb_we_nxt;
        end
    end

    // Payload
    always_ff @(posedge i_clk) begin
        o_wb_rd   <= i_rd_num;
        o_wb_data <= wb_data_nxt;
    end

endmodule

/* mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_valid,
    input  logic [isa_pkg::XLEN-1:0]            i_rs_2,
    input  logic [4:0]                          i_rd_num,
    input  logic [isa_pkg::XLEN-1:0]            i_alu_out,
    input  logic [6:0]                          i_opcode,
    input  logic [2:0]                          i_func_3,
    input  logic                                i_op_type,
    input  logic                                i_fault_clr,
    output logic                                o_wb_valid,
    output logic                                o_wb_we,
    output logic [4:0]                          o_wb_rd,
    output logic [isa_pkg::XLEN-1:0]            o_wb_data,
    output logic                                o_fault_flag,
    output logic [mem_map_pkg::FAULT_CNT_W-1:0] o_fault_count,
    output logic [isa_pkg::XLEN-1:0]            o_fault_addr
);
    import isa_pkg::*;

    logic [XLEN-1:0] mem_out;
    logic            is_load;
    logic            misaligned;
    logic            fault;
    logic [XLEN-1:0] fault_addr;

    mem_bus_if bus_i ();

    // ****************************************
    // Access stage and data memory
    // ****************************************
    mem_access_stage stage_i (
        .i_rs_2       (i_rs_2),
        .i_alu_out    (i_alu_out),
        .i_opcode     (i_opcode),
        .i_func_3     (i_func_3),
        .i_valid      (i_valid),
        .bus          (bus_i.master),
        .o_mem_out    (mem_out),
        .o_is_load    (is_load),
        .o_misaligned (misaligned),
        .o_fault      (fault),
        .o_fault_addr (fault_addr)
    );

    data_mem_ctrl dmem_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (bus_i.slave)
    );

    mem_fault_regs fault_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_fault       (fault),
        .i_fault_addr  (fault_addr),
        .i_fault_clr   (i_fault_clr),
        .o_fault_flag  (o_fault_flag),
        .o_fault_count (o_fault_count),
        .o_fault_addr  (o_fault_addr)
    );

    // ****************************************
    // Write-back register to stage five
    // ****************************************
    mem_wb_reg wb_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .i_rd_num     (i_rd_num),
        .i_alu_out    (i_alu_out),
        .i_mem_out    (mem_out),
        .i_is_load    (is_load),
        .i_op_type    (i_op_type),
        .i_misaligned (misaligned),
        .o_wb_valid   (o_wb_valid),
        .o_wb_we      (o_wb_we),
        .o_wb_rd      (o_wb_rd),
        .o_wb_data    (o_wb_data)
    );

endmodule

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
    import isa_pkg::*;
    import mem_map_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int N_RAND       = 16;
    localparam int N_PIPE       = 8;
    localparam int N_ACCESSES   = MEM_WORDS + 2 * N_RAND + 13 + 26 + N_PIPE + 10;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 2 * N_ACCESSES + 50) * CLK_PERIOD;
    localparam logic [6:0] OPC_OP = 7'b0110011;  // Register ALU op

    logic                   clk;
    logic                   rst_n;
    logic                   valid;
    logic [XLEN-1:0]        rs_2;
    logic [4:0]             rd_num;
    logic [XLEN-1:0]        alu_out;
    logic [6:0]             opcode;
    logic [2:0]             func_3;
    logic                   op_type;
    logic                   fault_clr;
    logic                   wb_valid;
    logic                   wb_we;
    logic [4:0]             wb_rd;
    logic [XLEN-1:0]        wb_data;
    logic                   fault_flag;
    logic [FAULT_CNT_W-1:0] fault_count;
    logic [XLEN-1:0]        fault_addr;

    logic [7:0]             mem_model [1024];  // Byte view of data memory
    logic                   m_flag;
    logic [FAULT_CNT_W-1:0] m_count;
    logic [XLEN-1:0]        m_addr;
    integer                 seed = 82759;
    int                     errors = 0;

    mem_subsystem_top dut_i (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_valid       (valid),
        .i_rs_2        (rs_2),
        .i_rd_num      (rd_num),
        .i_alu_out     (alu_out),
        .i_opcode      (opcode),
        .i_func_3      (func_3),
        .i_op_type     (op_type),
        .i_fault_clr   (fault_clr),
        .o_wb_valid    (wb_valid),
        .o_wb_we       (wb_we),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data),
        .o_fault_flag  (fault_flag),
        .o_fault_count (fault_count),
        .o_fault_addr  (fault_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ****************************************
    // Reference model
    // ****************************************
    task automatic predict(input logic [6:0] opc, input logic [2:0] f3,
                           input logic [XLEN-1:0] addr, input logic [XLEN-1:0] rs2,
                           input logic [4:0] rd, input logic wr,
                           output logic [XLEN-1:0] data, output logic we, output logic bad);
        logic            is_ld;
        logic            is_st;
        int              nbytes;
        logic [9:0]      idx;
        logic [XLEN-1:0] raw;
        is_ld  = (opc == OPC_LOAD) && (f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU});
        is_st  = (opc == OPC_STORE) && (f3 inside {F3_SB, F3_SH, F3_SW});
        nbytes = (f3[1:0] == 2'd0) ? 1 : ((f3[1:0] == 2'd1) ? 2 : 4);
        bad    = (is_ld || is_st) && ((int'(addr[1:0]) % nbytes) != 0);
        raw    = '0;
        for (int k = 0; k < nbytes; k++) begin
            idx = addr[9:0] + 10'(k);  // Byte address wraps at 1 KiB
            raw[8*k +: 8] = mem_model[idx];
        end
        if (!f3[2] && raw[8*nbytes-1]) begin
            for (int k = nbytes; k < 4; k++) raw[8*k +: 8] = 8'hff;  // Sign fill
        end
        data = is_ld ? raw : addr;
        we   = wr && (rd != 5'd0) && !bad;
        if (is_st && !bad) begin
            for (int k = 0; k < nbytes; k++) begin
                idx = addr[9:0] + 10'(k);
                mem_model[idx] = rs2[8*k +: 8];
            end
        end
        if (bad) begin
            m_flag = 1'b1;
            if (m_count != '1) m_count = m_count + 1'b1;
            m_addr = addr;
        end
    endtask

    task automatic drive(input logic [6:0] opc, input logic [2:0] f3, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] rs2, input logic [4:0] rd, input logic wr);
        valid   <= 1'b1;
        opcode  <= opc;
        func_3  <= f3;
        alu_out <= addr;
        rs_2    <= rs2;
        rd_num  <= rd;
        op_type <= wr;
    endtask

    task automatic check_wb(input logic [4:0] rd, input logic [XLEN-1:0] data, input logic we,
                            input logic bad, input string what);
        if (wb_valid !== 1'b1) begin
            errors++;
            $display("mismatch at %0t: %s wb_valid=%b", $time, what, wb_valid);
        end
        if (wb_rd !== rd) begin
            errors++;
            $display("mismatch at %0t: %s wb_rd=%0d expected %0d", $time, what, wb_rd, rd);
        end
        if (wb_we !== we) begin
            errors++;
            $display("mismatch at %0t: %s wb_we=%b expected %b", $time, what, wb_we, we);
        end
        if (!bad && wb_data !== data) begin  // Data of a faulting access is don't care
            errors++;
            $display("mismatch at %0t: %s wb_data=%h expected %h", $time, what, wb_data, data);
        end
    endtask

    task automatic check_faults(input string what);
        if (fault_flag !== m_flag || fault_count !== m_count || fault_addr !== m_addr) begin
            errors++;
            $display("mismatch at %0t: %s fault flag/count/addr %b/%0d/%h expected %b/%0d/%h",
                     $time, what, fault_flag, fault_count, fault_addr, m_flag, m_count, m_addr);
        end
    endtask

    task automatic run_access(input logic [6:0] opc, input logic [2:0] f3,
                              input logic [XLEN-1:0] addr, input logic [XLEN-1:0] rs2,
                              input logic [4:0] rd, input logic wr, input string what);
        logic [XLEN-1:0] exp_data;
        logic            exp_we;
        logic            exp_bad;
        @(posedge clk);
        predict(opc, f3, addr, rs2, rd, wr, exp_data, exp_we, exp_bad);
        drive(opc, f3, addr, rs2, rd, wr);
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        check_wb(rd, exp_data, exp_we, exp_bad, what);
        check_faults(what);
    endtask

    // ****************************************
    // Directed tests
    // ****************************************
    task automatic fill_memory();
        logic [7:0] w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            w = 8'(i);
            run_access(OPC_STORE, F3_SW, 32'(i * 4), {w, ~w, w ^ 8'ha5, w ^ 8'h3c},
                       5'd0, 1'b0, "fill");
        end
    endtask

    task automatic test_word_round_trip();
        logic [XLEN-1:0] addrs [N_RAND];
        for (int i = 0; i < N_RAND; i++) begin
            addrs[i] = $random(seed);
            addrs[i][1:0] = 2'b00;  // Upper bits stay random to exercise wrap
            run_access(OPC_STORE, F3_SW, addrs[i], $random(seed), 5'd1, 1'b0, "sw");
        end
        for (int i = N_RAND - 1; i >= 0; i--) begin  // First load hits the last store
            run_access(OPC_LOAD, F3_LW, addrs[i], $random(seed), 5'(i + 1), 1'b1, "lw");
        end
    endtask

    task automatic test_sub_word_stores();
        logic [XLEN-1:0] base;
        base = $random(seed);
        base[1:0] = 2'b00;
        run_access(OPC_STORE, F3_SW, base, 32'h0, 5'd0, 1'b0, "sw clear");
        for (int lane = 0; lane < 4; lane++) begin
            run_access(OPC_STORE, F3_SB, base + lane, $random(seed), 5'd0, 1'b0, "sb");
            run_access(OPC_LOAD, F3_LW, base, 32'h0, 5'd5, 1'b1, "lw after sb");
        end
        for (int half = 0; half < 2; half++) begin
            run_access(OPC_STORE, F3_SH, base + 2 * half, $random(seed), 5'd0, 1'b0, "sh");
            run_access(OPC_LOAD, F3_LW, base, 32'h0, 5'd6, 1'b1, "lw after sh");
        end
    endtask

    task automatic test_load_extension();
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] pats [2];
        pats[0] = 32'hf4c3_a281;  // Every lane negative
        pats[1] = 32'h1273_3c45;  // Every lane positive
        base = $random(seed);
        base[1:0] = 2'b00;
        for (int p = 0; p < 2; p++) begin
            run_access(OPC_STORE, F3_SW, base, pats[p], 5'd0, 1'b0, "sw pattern");
            for (int lane = 0; lane < 4; lane++) begin
                run_access(OPC_LOAD, F3_LB, base + lane, 32'h0, 5'd10, 1'b1, "lb");
                run_access(OPC_LOAD, F3_LBU, base + lane, 32'h0, 5'd11, 1'b1, "lbu");
            end
            for (int half = 0; half < 2; half++) begin
                run_access(OPC_LOAD, F3_LH, base + 2 * half, 32'h0, 5'd12, 1'b1, "lh");
                run_access(OPC_LOAD, F3_LHU, base + 2 * half, 32'h0, 5'd13, 1'b1, "lhu");
            end
        end
    endtask

    task automatic test_pass_through();
        logic [XLEN-1:0] exp_data [N_PIPE];
        logic            exp_we [N_PIPE];
        logic [4:0]      exp_rd [N_PIPE];
        logic            exp_bad;
        logic [6:0]      opc;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] rs2;
        for (int k = 0; k <= N_PIPE; k++) begin
            @(posedge clk);
            if (k < N_PIPE) begin
                opc = (k % 4 == 1) ? OPC_STORE : ((k % 4 == 2) ? OPC_LOAD : OPC_OP);
                if (opc != OPC_LOAD) begin  // A load reuses the store address before it
                    addr = $random(seed);
                    addr[1:0] = 2'b00;
                end
                rs2 = $random(seed);
                exp_rd[k] = (k % 3 == 0) ? 5'd0 : 5'(k + 3);
                predict(opc, F3_SW, addr, rs2, exp_rd[k], k != 5,
                        exp_data[k], exp_we[k], exp_bad);
                drive(opc, F3_SW, addr, rs2, exp_rd[k], k != 5);
            end else begin
                valid <= 1'b0;
            end
            @(negedge clk);
            if (k > 0) check_wb(exp_rd[k-1], exp_data[k-1], exp_we[k-1], 1'b0, "pipelined");
        end
    endtask

    task automatic test_misaligned();
        logic [XLEN-1:0] base;
        base = $random(seed);
        base[1:0] = 2'b00;
        run_access(OPC_STORE, F3_SW, base, 32'h5a5a_c3c3, 5'd0, 1'b0, "sw setup");
        run_access(OPC_LOAD, F3_LH, base + 1, 32'h0, 5'd7, 1'b1, "lh offset 1");
        run_access(OPC_LOAD, F3_LH, base + 3, 32'h0, 5'd7, 1'b1, "lh offset 3");
        run_access(OPC_LOAD, F3_LW, base + 2, 32'h0, 5'd7, 1'b1, "lw offset 2");
        run_access(OPC_STORE, F3_SW, base + 1, $random(seed), 5'd0, 1'b0, "sw offset 1");
        run_access(OPC_LOAD, F3_LW, base, 32'h0, 5'd8, 1'b1, "lw unchanged");
        // Clear and a new fault in the same cycle
        @(posedge clk);
        drive(OPC_LOAD, F3_LW, base + 1, 32'h0, 5'd9, 1'b1);
        fault_clr <= 1'b1;
        @(posedge clk);
        valid     <= 1'b0;
        fault_clr <= 1'b0;
        @(negedge clk);
        m_flag  = 1'b0;
        m_count = '0;
        m_addr  = '0;
        check_faults("clear beats fault");
        if (wb_we !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: wb_we set on a misaligned load", $time);
        end
        run_access(OPC_LOAD, F3_LW, base + 3, 32'h0, 5'd9, 1'b1, "fault after clear");
        @(posedge clk);
        fault_clr <= 1'b1;
        @(posedge clk);
        fault_clr <= 1'b0;
        @(negedge clk);
        m_flag  = 1'b0;
        m_count = '0;
        m_addr  = '0;
        check_faults("plain clear");
    endtask

    // ****************************************
    // Main sequence and watchdog
    // ****************************************
    initial begin
        rst_n     <= 1'b0;
        valid     <= 1'b0;
        rs_2      <= '0;
        rd_num    <= '0;
        alu_out   <= '0;
        opcode    <= '0;
        func_3    <= '0;
        op_type   <= 1'b0;
        fault_clr <= 1'b0;
        m_flag  = 1'b0;
        m_count = '0;
        m_addr  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (wb_valid !== 1'b0 || wb_we !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: write-back not idle after reset", $time);
        end
        check_faults("after reset");
        fill_memory();
        test_word_round_trip();
        test_sub_word_stores();
        test_load_extension();
        test_pass_through();
        test_misaligned();
        $display("Checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* project.f */
isa_pkg.sv
mem_map_pkg.sv
mem_bus_if.sv
mem_access_stage.sv
data_mem_ctrl.sv
mem_fault_regs.sv
mem_wb_reg.sv
mem_subsystem_top.sv
tb_mem_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_mem_subsystem \
    -f project.f \
    -o sim_mem

./obj_dir/sim_mem > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run failed, see sim.log"
    exit 1
fi
exit 0
